// ==== Bender.yml ====
package:
  name: awe_row_buffers

sources:
  - src/row_buffer_pkg.sv
  - src/row_buffer_if.sv
  - src/row_buffer_ram.sv
  - src/seq_addr_decode.sv
  - src/row_buffer_ctrl.sv
  - src/pixel_pair_capture.sv
  - src/awe_row_buffers.sv
  - target: test
    files:
      - dv/awe_row_buffers_tb.sv

// ==== awe_row_buffers.f ====
src/row_buffer_pkg.sv
src/row_buffer_if.sv
src/row_buffer_ram.sv
src/seq_addr_decode.sv
src/row_buffer_ctrl.sv
src/pixel_pair_capture.sv
src/awe_row_buffers.sv
dv/awe_row_buffers_tb.sv

// ==== dv/awe_row_buffers_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module awe_row_buffers_tb
    import row_buffer_pkg::*;
();

    localparam int burst_timeout = 400;

    logic                     clk_500MHz = 1'b0;
    logic                     accel_rst = 1'b1;
    logic [col_width-1:0]     input_row = '0;
    logic [col_width-1:0]     input_col = '0;
    logic [col_width-1:0]     wr_addr = '0;
    logic [col_width-1:0]     num_input_cols = 9'd255;
    logic [3:0]               state = st_idle;
    logic [1:0]               gray_code = '0;
    logic [seq_width-1:0]     seq_datain = '0;
    logic [cycle_width-1:0]   cycle_counter = 6'd63;
    logic                     row_matric = 1'b0;
    logic                     pfb_rden = 1'b0;
    logic                     ce_start = 1'b0;
    logic [pixel_width-1:0]   pixel_datain = '0;
    logic [2*pixel_width-1:0] pixel_dataout;

    integer                 seed = 32'hbc30_fa53;
    logic [pixel_width-1:0] even_model [int];
    logic [pixel_width-1:0] odd_model [int];
    logic [seq_width-1:0]   stim_words [$];
    logic [1:0]             stim_grays [$];

    awe_row_buffers dut_i (.*);

    initial begin
        forever #20 clk_500MHz = ~clk_500MHz;
    end

    task automatic flag_mismatch(input string msg);
        $display("FAIL at %0d ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic abort_timeout(input string msg);
        $display("Timed out: %s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    // Output pair only moves on an active read
    assert property (@(posedge clk_500MHz) disable iff (accel_rst)
        !ce_start |=> $stable(pixel_dataout))
        else flag_mismatch("pixel pair changed with ce_start low");

    //////////////////////////////
    // Address rules of the sequence word
    //////////////////////////////
    function automatic logic [ram_addr_width-1:0] even_addr(logic [15:0] w, logic [1:0] g);
        return {w[15] ^ g[0], w[8:0]};
    endfunction

    function automatic logic [ram_addr_width-1:0] odd_addr(logic [15:0] w, logic [1:0] g);
        return {w[15] ^ g[1], w[8:1], w[0] | w[9]};
    endfunction

    task automatic prime_pixel(input int row, input int col, input logic [15:0] pix);
        @(negedge clk_500MHz);
        state        = st_prim_buffer;
        pfb_rden     = 1'b1;
        input_row    = row[col_width-1:0];
        input_col    = col[col_width-1:0];
        pixel_datain = pix;
        // Row 0 in bank 0 of both, row 1 odd bank 1, row 2 even bank 1
        if (col <= num_input_cols && row != 2)
            odd_model[{row == 1, input_col}] = pix;
        if (col <= num_input_cols && row != 1)
            even_model[{row == 2, input_col}] = pix;
    endtask

    task automatic idle_cycles(input int n);
        logic [2*pixel_width-1:0] held;
        logic [31:0]              r;
        held = pixel_dataout;
        repeat (n) begin
            @(negedge clk_500MHz);
            assert (pixel_dataout === held)
                else flag_mismatch("pixel pair changed in an idle state");
            r             = $random(seed);
            state         = r[0] ? st_idle : st_wait_pfb_load;
            pfb_rden      = r[1];
            ce_start      = r[2];
            row_matric    = r[3];
            gray_code     = r[5:4];
            input_row     = {7'd0, r[7:6]};
            input_col     = r[16:8];
            wr_addr       = r[25:17];
            seq_datain    = r[31:16];
            pixel_datain  = r[23:8];
            cycle_counter = r[29:24];
        end
        @(negedge clk_500MHz);
        assert (pixel_dataout === held)
            else flag_mismatch("pixel pair changed in an idle state");
        state      = st_idle;
        pfb_rden   = 1'b0;
        ce_start   = 1'b0;
        row_matric = 1'b0;
    endtask

    // Streams the queued words and checks each pair three edges later
    task automatic read_burst();
        logic [2*pixel_width-1:0] expected [$];
        int                       due [$];
        int                       cycle;
        logic [31:0]              r;
        cycle = 0;
        while (stim_words.size() > 0 || expected.size() > 0) begin
            @(negedge clk_500MHz);
            if (cycle > burst_timeout)
                abort_timeout("expected pixel pairs never drained");
            if (due.size() > 0 && due[0] == cycle) begin
                assert (pixel_dataout === expected[0])
                    else flag_mismatch($sformatf("pixel pair %h, expected %h",
                                                 pixel_dataout, expected[0]));
                void'(expected.pop_front());
                void'(due.pop_front());
            end
            r        = $random(seed);
            state    = st_ce_active;
            ce_start = 1'b1;
            if (stim_words.size() > 0) begin
                seq_datain = stim_words.pop_front();
                gray_code  = stim_grays.pop_front();
                expected.push_back({odd_model[odd_addr(seq_datain, gray_code)],
                                    even_model[even_addr(seq_datain, gray_code)]});
                due.push_back(cycle + 3);
            end else begin
                seq_datain = {r[15:9], 1'b0, r[7:0]};
                gray_code  = r[17:16];
            end
            cycle++;
        end
        @(negedge clk_500MHz);
        ce_start = 1'b0;
        state    = st_idle;
    endtask

    task automatic rename_pixel(input logic [1:0] g, input int col,
                                input logic [15:0] pix, input logic [15:0] w);
        logic [pixel_width-1:0] saved;
        // Read the row that is about to be renamed
        @(negedge clk_500MHz);
        state      = st_ce_active;
        ce_start   = 1'b1;
        seq_datain = w;
        gray_code  = g;
        // A second read replaces rd_data right after the save cycle
        @(negedge clk_500MHz);
        seq_datain = w ^ 16'h0002;
        @(negedge clk_500MHz);
        ce_start      = 1'b0;
        cycle_counter = (g == 2'b00 || g == 2'b01) ? save_cycle_early : save_cycle_late;
        saved = (g == 2'b00 || g == 2'b11) ? odd_model[odd_addr(w, g)]
                                           : even_model[even_addr(w, g)];
        @(negedge clk_500MHz);
        cycle_counter = 6'd63;
        @(negedge clk_500MHz);
        ce_start      = 1'b1;
        row_matric    = 1'b1;
        wr_addr       = col[8:0];
        pixel_datain  = pix;
        if (g[0] == g[1]) begin
            odd_model[{g[0], col[8:0]}]  = pix;
            even_model[{g[1], col[8:0]}] = saved;
        end else begin
            even_model[{g[0], col[8:0]}] = pix;
            odd_model[{g[1], col[8:0]}]  = saved;
        end
        @(negedge clk_500MHz);
        ce_start   = 1'b0;
        row_matric = 1'b0;
        state      = st_idle;
    endtask

    initial begin
        logic [31:0] r;
        repeat (4) @(negedge clk_500MHz);
        accel_rst = 1'b0;
        assert (pixel_dataout === '0)
            else flag_mismatch("pixel pair not cleared by reset");
        idle_cycles(10);

        //////////////////////////////
        // Prime load and a narrow rewrite
        //////////////////////////////
        for (int row = 0; row < 3; row++) begin
            for (int col = 0; col < 256; col++) begin
                r = $random(seed);
                prime_pixel(row, col, r[15:0]);
            end
        end
        idle_cycles(4);
        num_input_cols = 9'd100;
        for (int row = 0; row < 3; row++) begin
            for (int col = 90; col <= 120; col++) begin
                r = $random(seed);
                prime_pixel(row, col, r[15:0]);
            end
        end
        idle_cycles(10);

        // Band around the column limit in both banks
        for (int col = 90; col <= 120; col++) begin
            for (int b = 0; b < 2; b++) begin
                stim_words.push_back({b[0], 6'd0, col[8:0]});
                stim_grays.push_back(2'b00);
            end
        end
        // Bank bit, parity bit and low bit under every gray code
        for (int g = 0; g < 4; g++) begin
            stim_words.push_back(16'h8025);
            stim_words.push_back(16'h022a);
            stim_words.push_back(16'h00b3);
            stim_words.push_back(16'h822b);
            repeat (4) stim_grays.push_back(g[1:0]);
        end
        repeat (120) begin
            r = $random(seed);
            stim_words.push_back({r[15:9], 1'b0, r[7:0]});
            stim_grays.push_back(r[17:16]);
        end
        read_burst();

        //////////////////////////////
        // Row rename and readback
        //////////////////////////////
        for (int g = 0; g < 4; g++) begin
            r = $random(seed);
            rename_pixel(g[1:0], 200 + g, r[15:0], {r[31:25], 1'b0, r[23:16]});
        end
        for (int g = 0; g < 4; g++) begin
            stim_words.push_back(16'(200 + g));
            stim_grays.push_back(g[1:0]);
        end
        read_burst();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/awe_row_buffers.sv ====
`timescale 1ns/1ps
`default_nettype none

module awe_row_buffers
    import row_buffer_pkg::*;
(
    input  logic                     clk_500MHz,
    input  logic                     accel_rst,
    input  logic [col_width-1:0]     input_row,
    input  logic [col_width-1:0]     input_col,
    input  logic [col_width-1:0]     num_input_cols,
    input  logic [col_width-1:0]     wr_addr,
    input  logic [3:0]               state,
    input  logic [1:0]               gray_code,
    input  logic [seq_width-1:0]     seq_datain,
    input  logic [cycle_width-1:0]   cycle_counter,
    input  logic                     row_matric,
    input  logic                     pfb_rden,
    input  logic                     ce_start,
    input  logic [pixel_width-1:0]   pixel_datain,
    output logic [2*pixel_width-1:0] pixel_dataout
);

    logic [ram_addr_width-1:0] even_rd_addr;
    logic [ram_addr_width-1:0] odd_rd_addr;
    logic [pixel_width-1:0]    saved_pixel;

    row_buffer_if even_buf ();
    row_buffer_if odd_buf ();

    //////////////////////////////
    // Address decode and control
    //////////////////////////////
    seq_addr_decode seq_addr_decode_i (
        .seq_datain   (seq_datain),
        .gray_code    (gray_code),
        .even_rd_addr (even_rd_addr),
        .odd_rd_addr  (odd_rd_addr)
    );

    row_buffer_ctrl row_buffer_ctrl_i (
        .clk_500MHz     (clk_500MHz),
        .accel_rst      (accel_rst),
        .state          (state),
        .pfb_rden       (pfb_rden),
        .ce_start       (ce_start),
        .row_matric     (row_matric),
        .input_row      (input_row),
        .input_col      (input_col),
        .num_input_cols (num_input_cols),
        .wr_addr        (wr_addr),
        .gray_code      (gray_code),
        .pixel_datain   (pixel_datain),
        .even_rd_addr   (even_rd_addr),
        .odd_rd_addr    (odd_rd_addr),
        .saved_pixel    (saved_pixel),
        .even_buf       (even_buf.ctrl),
        .odd_buf        (odd_buf.ctrl)
    );

    //////////////////////////////
    // Row memories and capture
    //////////////////////////////
    row_buffer_ram even_ram_i (
        .clk_500MHz (clk_500MHz),
        .mem        (even_buf.ram)
    );

    row_buffer_ram odd_ram_i (
        .clk_500MHz (clk_500MHz),
        .mem        (odd_buf.ram)
    );

    pixel_pair_capture pixel_pair_capture_i (
        .clk_500MHz    (clk_500MHz),
        .accel_rst     (accel_rst),
        .ce_start      (ce_start),
        .gray_code     (gray_code),
        .cycle_counter (cycle_counter),
        .even_buf      (even_buf.mon),
        .odd_buf       (odd_buf.mon),
        .saved_pixel   (saved_pixel),
        .pixel_dataout (pixel_dataout)
    );

endmodule

`default_nettype wire

// ==== src/pixel_pair_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_pair_capture
    import row_buffer_pkg::*;
(
    input  logic                       clk_500MHz,
    input  logic                       accel_rst,
    input  logic                       ce_start,
    input  logic [1:0]                 gray_code,
    input  logic [cycle_width-1:0]     cycle_counter,
    row_buffer_if.mon                  even_buf,
    row_buffer_if.mon                  odd_buf,
    output logic [pixel_width-1:0]     saved_pixel,
    output logic [2*pixel_width-1:0]   pixel_dataout
);

    logic at_early;
    logic at_late;
    logic take_odd;
    logic take_even;

    assign at_early = cycle_counter == save_cycle_early;
    assign at_late  = cycle_counter == save_cycle_late;

    // Which memory holds the row about to be renamed
    assign take_odd  = (gray_code == 2'b00 && at_early) || (gray_code == 2'b11 && at_late);
    assign take_even = (gray_code == 2'b01 && at_early) || (gray_code == 2'b10 && at_late);

    //////////////////////////////
    // Saved pixel
    //////////////////////////////
    always_ff @(posedge clk_500MHz) begin
        if (take_odd) begin
            saved_pixel <= odd_buf.rd_data;
        end else if (take_even) begin
            saved_pixel <= even_buf.rd_data;
        end
    end

    //////////////////////////////
    // Output pair, odd pixel on top
    //////////////////////////////
    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            pixel_dataout <= '0;
        end else if (ce_start && even_buf.rden) begin
            pixel_dataout <= {odd_buf.rd_data, even_buf.rd_data};
        end
    end

endmodule

`default_nettype wire

// ==== src/row_buffer_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_buffer_ctrl
    import row_buffer_pkg::*;
(
    input  logic                      clk_500MHz,
    input  logic                      accel_rst,
    input  logic [3:0]                state,
    input  logic                      pfb_rden,
    input  logic                      ce_start,
    input  logic                      row_matric,
    input  logic [col_width-1:0]      input_row,
    input  logic [col_width-1:0]      input_col,
    input  logic [col_width-1:0]      num_input_cols,
    input  logic [col_width-1:0]      wr_addr,
    input  logic [1:0]                gray_code,
    input  logic [pixel_width-1:0]    pixel_datain,
    input  logic [ram_addr_width-1:0] even_rd_addr,
    input  logic [ram_addr_width-1:0] odd_rd_addr,
    input  logic [pixel_width-1:0]    saved_pixel,
    row_buffer_if.ctrl                even_buf,
    row_buffer_if.ctrl                odd_buf
);

    logic col_in_range;

    assign col_in_range = input_col <= num_input_cols;

    always_ff @(posedge clk_500MHz) begin
        if (accel_rst) begin
            even_buf.wren <= 1'b0;
            even_buf.rden <= 1'b0;
            odd_buf.wren  <= 1'b0;
            odd_buf.rden  <= 1'b0;
        end else begin
            // Strobes last one cycle
            even_buf.wren <= 1'b0;
            even_buf.rden <= 1'b0;
            odd_buf.wren  <= 1'b0;
            odd_buf.rden  <= 1'b0;

            case (state)
                //////////////////////////////
                // Prime load of rows 0..2
                //////////////////////////////
                st_prim_buffer: begin
                    if (pfb_rden && col_in_range) begin
                        case (input_row)
                            9'd0: begin
                                // Row 0 lands in bank 0 of both memories
                                even_buf.wren    <= 1'b1;
                                even_buf.wr_addr <= {1'b0, input_col};
                                even_buf.wr_data <= pixel_datain;
                                odd_buf.wren     <= 1'b1;
                                odd_buf.wr_addr  <= {1'b0, input_col};
                                odd_buf.wr_data  <= pixel_datain;
                            end
                            9'd1: begin
                                odd_buf.wren    <= 1'b1;
                                odd_buf.wr_addr <= {1'b1, input_col};
                                odd_buf.wr_data <= pixel_datain;
                            end
                            9'd2: begin
                                even_buf.wren    <= 1'b1;
                                even_buf.wr_addr <= {1'b1, input_col};
                                even_buf.wr_data <= pixel_datain;
                            end
                            default: ;
                        endcase
                    end
                end

                //////////////////////////////
                // Active reads and row rename
                //////////////////////////////
                st_ce_active: begin
                    if (ce_start) begin
                        even_buf.rden    <= 1'b1;
                        odd_buf.rden     <= 1'b1;
                        even_buf.rd_addr <= even_rd_addr;
                        odd_buf.rd_addr  <= odd_rd_addr;
                        if (row_matric) begin
                            even_buf.wren <= 1'b1;
                            odd_buf.wren  <= 1'b1;
                            if (gray_code[0] == gray_code[1]) begin
                                // Incoming row to odd, saved pixel renamed into even
                                odd_buf.wr_addr  <= {gray_code[0], wr_addr};
                                odd_buf.wr_data  <= pixel_datain;
                                even_buf.wr_addr <= {gray_code[1], wr_addr};
                                even_buf.wr_data <= saved_pixel;
                            end else begin
                                even_buf.wr_addr <= {gray_code[0], wr_addr};
                                even_buf.wr_data <= pixel_datain;
                                odd_buf.wr_addr  <= {gray_code[1], wr_addr};
                                odd_buf.wr_data  <= saved_pixel;
                            end
                        end
                    end
                end

                // No memory activity
                st_idle, st_wait_pfb_load: ;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/row_buffer_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Write port and read port of one row memory
interface row_buffer_if
    import row_buffer_pkg::*;
();

    logic [ram_addr_width-1:0] wr_addr;
    logic [ram_addr_width-1:0] rd_addr;
    logic [pixel_width-1:0]    wr_data;
    logic                      wren;
    logic                      rden;
    logic [pixel_width-1:0]    rd_data;

    modport ctrl (
        output wr_addr, rd_addr, wr_data, wren, rden,
        input  rd_data
    );

    modport ram (
        input  wr_addr, rd_addr, wr_data, wren, rden,
        output rd_data
    );

    // Read side only, for the pixel capture
    modport mon (
        input rd_data, rden
    );

endinterface

`default_nettype wire

// ==== src/row_buffer_pkg.sv ====
`default_nettype none

package row_buffer_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int pixel_width    = 16;
    localparam int ram_depth      = 1024;
    localparam int ram_addr_width = 10;
    localparam int col_width      = 9;
    localparam int seq_width      = 16;
    localparam int cycle_width    = 6;

    //////////////////////////////
    // Accelerator states, one-hot
    //////////////////////////////
    localparam logic [3:0] st_idle          = 4'b0001;
    localparam logic [3:0] st_prim_buffer   = 4'b0010;
    localparam logic [3:0] st_wait_pfb_load = 4'b0100;
    localparam logic [3:0] st_ce_active     = 4'b1000;

    // Cycle counter values where the saved pixel is taken
    localparam logic [cycle_width-1:0] save_cycle_early = 6'd2;
    localparam logic [cycle_width-1:0] save_cycle_late  = 6'd0;

    //////////////////////////////
    // Sequence word
    //////////////////////////////
    typedef struct packed {
        logic       bank_sel;
        logic [5:0] spare;
        logic [8:0] col;
    } seq_even_t;

    typedef struct packed {
        logic       bank_sel;
        logic [4:0] spare;
        logic       parity;
        logic [7:0] col_hi;
        logic       col_lo;
    } seq_odd_t;

    // Same word, decoded once per memory
    typedef union packed {
        seq_even_t even;
        seq_odd_t  odd;
    } seq_word_u;

endpackage

`default_nettype wire

// ==== src/row_buffer_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module row_buffer_ram
    import row_buffer_pkg::*;
(
    input  logic      clk_500MHz,
    row_buffer_if.ram mem
);

    logic [pixel_width-1:0] ram_q [ram_depth];

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge clk_500MHz) begin
        if (mem.wren) begin
            ram_q[mem.wr_addr] <= mem.wr_data;
        end
    end

    //////////////////////////////
    // Registered read port
    //////////////////////////////
    // Read before write on a collision, output holds when idle
    always_ff @(posedge clk_500MHz) begin
        if (mem.rden) begin
            mem.rd_data <= ram_q[mem.rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/seq_addr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module seq_addr_decode
    import row_buffer_pkg::*;
(
    input  seq_word_u                 seq_datain,
    input  logic [1:0]                gray_code,
    output logic [ram_addr_width-1:0] even_rd_addr,
    output logic [ram_addr_width-1:0] odd_rd_addr
);

    logic even_bank;
    logic odd_bank;
    logic odd_col_lo;

    // Gray code rotates which bank holds which row
    assign even_bank = seq_datain.even.bank_sel ^ gray_code[0];
    assign odd_bank  = seq_datain.odd.bank_sel ^ gray_code[1];

    // Parity forces the odd column onto an odd word
    assign odd_col_lo = seq_datain.odd.col_lo | seq_datain.odd.parity;

    //////////////////////////////
    // Read addresses
    //////////////////////////////
    assign even_rd_addr = {
        even_bank,
        seq_datain.even.col
    };

    assign odd_rd_addr = {
        odd_bank,
        seq_datain.odd.col_hi,
        odd_col_lo
    };

endmodule

`default_nettype wire
